// ==== logic/stream_switch_params.svh ====
`ifndef STREAM_SWITCH_PARAMS_SVH
`define STREAM_SWITCH_PARAMS_SVH

// ======================================================================
// Stream counts and widths
// ======================================================================
`define NUM_STREAMS 8
`define SAMPLE_W 16
`define DWELL_W 16
`define SEL_W 4
`define APB_AW 4

// ======================================================================
// Selection codes and reset values
// ======================================================================
`define BT_SEL 8 // Index just past the wired streams.
`define DWELL_RESET 385
`define DWELL_MIN 2 // Shortest dwell the timer will honour.
`define MASK_RESET 8'hFF
`define CTRL_RESET 1'b1

`endif

// ==== logic/stream_switch_pkg.sv ====
`include "stream_switch_params.svh"

package stream_switch_pkg;

	// Values 0 to 7 name a wired stream, BT_SEL names the Bluetooth source.
	typedef logic [`SEL_W-1:0] sel_t;

	typedef logic [`SAMPLE_W-1:0] sample_t;

	typedef logic [`DWELL_W-1:0] dwell_t;

	// Register offsets on the APB side.
	typedef enum logic [`APB_AW-1:0] {
		REG_CTRL   = 4'h0,
		REG_DWELL  = 4'h4,
		REG_MASK   = 4'h8,
		REG_STATUS = 4'hC
	} reg_addr_e;

endpackage

// ==== logic/dwell_timer.sv ====
`timescale 1ns/1ps
`include "stream_switch_params.svh"

module dwell_timer (
	input  logic                      clock,
	input  logic                      rst_n,
	input  logic                      scan_en,
	input  logic                      bt_state,
	input  stream_switch_pkg::dwell_t dwell_cycles,
	output logic                      expired
);
	import stream_switch_pkg::*;

	dwell_t count;
	dwell_t last_count; // Count value on which the pulse fires.
	logic   run;

	// The timer only runs while scanning is on and Bluetooth is not forcing the source.
	assign run = scan_en & bt_state;

	always_comb
	begin
		if (dwell_cycles < dwell_t'(`DWELL_MIN))
			last_count = dwell_t'(`DWELL_MIN - 1);
		else
			last_count = dwell_cycles - dwell_t'(1);
	end

	assign expired = run && (count == last_count);

	// Restarting at zero on the pulse keeps expiries exactly one dwell apart.
	always_ff @(posedge clock)
	begin
		if (!rst_n)
			count <= '0;
		else if (!run || expired)
			count <= '0;
		else
			count <= count + dwell_t'(1);
	end

endmodule

// ==== logic/stream_scan_arbiter.sv ====
`timescale 1ns/1ps
`include "stream_switch_params.svh"

module stream_scan_arbiter (
	input  logic                    clock,
	input  logic                    rst_n,
	input  logic                    bt_state,
	input  logic                    expired,
	input  logic [`NUM_STREAMS-1:0] open_streams,
	input  logic [`NUM_STREAMS-1:0] stream_mask,
	output stream_switch_pkg::sel_t sel,
	output logic                    sel_valid
);
	import stream_switch_pkg::*;

	localparam int IDX_W = $clog2(`NUM_STREAMS);

	logic [`NUM_STREAMS-1:0] eligible;
	logic [IDX_W-1:0]        last_idx;   // Scan position, kept through an override.
	logic                    held_valid; // Validity of the scan position.
	logic                    override;
	logic [IDX_W-1:0]        cand;
	logic [IDX_W-1:0]        next_idx;
	logic                    hit;

	// ======================================================================
	// Round-robin search
	// ======================================================================
	assign eligible = open_streams & stream_mask;

	// The current stream is looked at last, so it is kept only if nothing else is open.
	always_comb
	begin
		hit = 1'b0;
		next_idx = last_idx;
		cand = last_idx;
		for (int i = 1; i <= `NUM_STREAMS; i++)
		begin
			cand = IDX_W'(last_idx + i);
			if (!hit && eligible[cand])
			begin
				hit = 1'b1;
				next_idx = cand;
			end
		end
	end

	// ======================================================================
	// Selection register
	// ======================================================================
	always_ff @(posedge clock)
	begin
		if (!rst_n)
		begin
			sel        <= '0;
			sel_valid  <= 1'b0;
			last_idx   <= '0;
			held_valid <= 1'b0;
			override   <= 1'b0;
		end
		else if (!bt_state)
		begin
			sel       <= sel_t'(`BT_SEL); // Idle link forces the Bluetooth source.
			sel_valid <= 1'b1;
			override  <= 1'b1;
		end
		else if (override)
		begin
			sel       <= sel_t'(last_idx);
			sel_valid <= held_valid;
			override  <= 1'b0;
		end
		else if (expired)
		begin
			held_valid <= hit;
			sel_valid  <= hit;
			if (hit)
			begin
				sel      <= sel_t'(next_idx);
				last_idx <= next_idx;
			end
		end
	end

endmodule

// ==== logic/stream_mux.sv ====
`timescale 1ns/1ps
`include "stream_switch_params.svh"

module stream_mux (
	input  logic                                         clock,
	input  logic                                         rst_n,
	input  stream_switch_pkg::sel_t                      sel,
	input  logic                                         sel_valid,
	input  stream_switch_pkg::sample_t [`NUM_STREAMS-1:0] stream_samples,
	input  stream_switch_pkg::sample_t                   bt_sample,
	output stream_switch_pkg::sample_t                   sample_out
);
	import stream_switch_pkg::*;

	localparam int IDX_W = $clog2(`NUM_STREAMS);

	sample_t pick;

	// An invalid selection plays silence.
	always_comb
	begin
		if (!sel_valid)
			pick = '0;
		else if (sel == sel_t'(`BT_SEL))
			pick = bt_sample;
		else if (sel < sel_t'(`NUM_STREAMS))
			pick = stream_samples[sel[IDX_W-1:0]];
		else
			pick = '0;
	end

	always_ff @(posedge clock)
	begin
		if (!rst_n)
			sample_out <= '0;
		else
			sample_out <= pick; // One cycle behind sel.
	end

endmodule

// ==== logic/switch_apb_regs.sv ====
`timescale 1ns/1ps
`include "stream_switch_params.svh"

module switch_apb_regs (
	input  logic                      clock,
	input  logic                      rst_n,
	input  logic                      psel,
	input  logic                      penable,
	input  logic                      pwrite,
	input  logic [`APB_AW-1:0]        paddr,
	input  logic [31:0]               pwdata,
	output logic [31:0]               prdata,
	output logic                      pready,
	output logic                      pslverr,
	input  stream_switch_pkg::sel_t   sel,
	input  logic                      sel_valid,
	input  logic                      bt_state,
	output logic                      scan_en,
	output stream_switch_pkg::dwell_t dwell_cycles,
	output logic [`NUM_STREAMS-1:0]   stream_mask
);
	import stream_switch_pkg::*;

	logic access;
	logic mapped;
	logic wr_en;
	logic rd_en;

	// ======================================================================
	// Address decode
	// ======================================================================
	assign access = psel & penable;
	assign pready = 1'b1; // No wait states.

	always_comb
	begin
		case (paddr)
			REG_CTRL, REG_DWELL, REG_MASK, REG_STATUS: mapped = 1'b1;
			default: mapped = 1'b0;
		endcase
	end

	// Status is read only.
	assign pslverr = access && (!mapped || (pwrite && paddr == REG_STATUS));

	assign wr_en = access & pwrite & ~pslverr;
	assign rd_en = access & ~pwrite;

	// ======================================================================
	// Writable registers
	// ======================================================================
	always_ff @(posedge clock)
	begin
		if (!rst_n)
		begin
			scan_en      <= `CTRL_RESET;
			dwell_cycles <= dwell_t'(`DWELL_RESET);
			stream_mask  <= `MASK_RESET;
		end
		else if (wr_en)
		begin
			case (paddr)
				REG_CTRL:  scan_en <= pwdata[0];
				REG_DWELL: dwell_cycles <= pwdata[`DWELL_W-1:0];
				REG_MASK:  stream_mask <= pwdata[`NUM_STREAMS-1:0];
				default:   scan_en <= scan_en;
			endcase
		end
	end

	// ======================================================================
	// Read data
	// ======================================================================
	always_comb
	begin
		prdata = '0;
		if (rd_en)
		begin
			case (paddr)
				REG_CTRL:   prdata = {31'd0, scan_en};
				REG_DWELL:  prdata = 32'(dwell_cycles);
				REG_MASK:   prdata = 32'(stream_mask);
				REG_STATUS: prdata = {26'd0, ~bt_state, sel_valid, sel}; // Bit 5 is the override.
				default:    prdata = '0;
			endcase
		end
	end

endmodule

// ==== logic/stream_switch_top.sv ====
`timescale 1ns/1ps
`include "stream_switch_params.svh"

module stream_switch_top (
	input  logic                                         clock,
	input  logic                                         rst_n,
	input  logic                                         bt_state,
	input  logic [`NUM_STREAMS-1:0]                      open_streams,
	input  stream_switch_pkg::sample_t [`NUM_STREAMS-1:0] stream_samples,
	input  stream_switch_pkg::sample_t                   bt_sample,
	input  logic                                         psel,
	input  logic                                         penable,
	input  logic                                         pwrite,
	input  logic [`APB_AW-1:0]                           paddr,
	input  logic [31:0]                                  pwdata,
	output logic [31:0]                                  prdata,
	output logic                                         pready,
	output logic                                         pslverr,
	output stream_switch_pkg::sel_t                      sel,
	output logic                                         sel_valid,
	output stream_switch_pkg::sample_t                   sample_out
);
	import stream_switch_pkg::*;

	logic                    scan_en;
	dwell_t                  dwell_cycles;
	logic [`NUM_STREAMS-1:0] stream_mask;
	logic                    expired;

	// ======================================================================
	// Software registers
	// ======================================================================
	switch_apb_regs switch_apb_regs_inst (
		.clock        (clock),
		.rst_n        (rst_n),
		.psel         (psel),
		.penable      (penable),
		.pwrite       (pwrite),
		.paddr        (paddr),
		.pwdata       (pwdata),
		.prdata       (prdata),
		.pready       (pready),
		.pslverr      (pslverr),
		.sel          (sel),
		.sel_valid    (sel_valid),
		.bt_state     (bt_state),
		.scan_en      (scan_en),
		.dwell_cycles (dwell_cycles),
		.stream_mask  (stream_mask)
	);

	// ======================================================================
	// Selection controller and output path
	// ======================================================================
	dwell_timer dwell_timer_inst (
		.clock        (clock),
		.rst_n        (rst_n),
		.scan_en      (scan_en),
		.bt_state     (bt_state),
		.dwell_cycles (dwell_cycles),
		.expired      (expired)
	);

	stream_scan_arbiter stream_scan_arbiter_inst (
		.clock        (clock),
		.rst_n        (rst_n),
		.bt_state     (bt_state),
		.expired      (expired),
		.open_streams (open_streams),
		.stream_mask  (stream_mask),
		.sel          (sel),
		.sel_valid    (sel_valid)
	);

	stream_mux stream_mux_inst (
		.clock          (clock),
		.rst_n          (rst_n),
		.sel            (sel),
		.sel_valid      (sel_valid),
		.stream_samples (stream_samples),
		.bt_sample      (bt_sample),
		.sample_out     (sample_out)
	);

endmodule

// ==== dv/stream_switch_checker.sv ====
`timescale 1ns/1ps
`include "stream_switch_params.svh"

module stream_switch_checker (
	input logic                    clock,
	input logic                    rst_n,
	input logic                    bt_state,
	input logic                    expired,
	input logic                    pready,
	input stream_switch_pkg::sel_t sel,
	input logic                    sel_valid
);
	import stream_switch_pkg::*;

	// ======================================================================
	// Selection and bus properties
	// ======================================================================
	assert property (@(posedge clock) !rst_n |=> !sel_valid)
		else $error("sel_valid high in the cycle after reset");

	assert property (@(posedge clock) disable iff (!rst_n)
		!bt_state |=> (sel == sel_t'(`BT_SEL)))
		else $error("sel is not the Bluetooth source after bt_state went low");

	assert property (@(posedge clock) pready)
		else $error("pready dropped");

	// A change of sel needs an expiry or a Bluetooth transition in the cycles before.
	assert property (@(posedge clock) disable iff (!rst_n)
		($past(rst_n) && sel != $past(sel))
		|-> ($past(expired) || !$past(bt_state) || !$past(bt_state, 2)))
		else $error("sel changed without expiry or Bluetooth event");

endmodule

// ==== dv/stream_switch_tb.sv ====
`timescale 1ns/1ps
`include "stream_switch_params.svh"

module stream_switch_tb;
	import stream_switch_pkg::*;

	localparam int CYC_REGS = 120;
	localparam int CYC_SCAN = 12 * 5 + 20;
	localparam int CYC_SKIP = 14 * 20;
	localparam int CYC_BT = 80;
	localparam int CYC_DIS = 80;
	localparam int MAX_CYCLES = 2 * (CYC_REGS + CYC_SCAN + CYC_SKIP + CYC_BT + CYC_DIS);

	logic clock = 1'b0;
	logic rst_n, bt_state, psel, penable, pwrite, pready, pslverr, sel_valid;
	logic [`NUM_STREAMS-1:0] open_streams;
	sample_t [`NUM_STREAMS-1:0] stream_samples = '0;
	sample_t bt_sample = '0;
	sample_t sample_out;
	logic [`APB_AW-1:0] paddr;
	logic [31:0] pwdata, prdata, rdata;
	sel_t sel, start_sel;
	integer seed = 43;
	int errors = 0;
	int checks = 0;
	int cycles = 0;
	int exp_count = 0;
	logic [11:0] tick = '0;
	// Shadow of the software registers, and the reference state.
	logic m_scan;
	dwell_t m_dwell, cnt;
	logic [`NUM_STREAMS-1:0] m_mask;
	sel_t m_sel;
	logic m_valid, m_hvalid, m_ovr, run, exp_now;
	logic [2:0] m_last;
	logic [4:0] nxt;
	sample_t m_sample;

	stream_switch_top stream_switch_top_inst (.*);

	bind stream_switch_top stream_switch_checker checker_inst (
		.clock(clock), .rst_n(rst_n), .bt_state(bt_state), .expired(expired),
		.pready(pready), .sel(sel), .sel_valid(sel_valid));

	always #20 clock = ~clock;

	// Bit 4 flags a hit, bits 2:0 give the stream found.
	function automatic logic [4:0] next_stream(logic [2:0] last, logic [7:0] open,
		logic [7:0] mask);
		logic [2:0] idx;
		for (int i = 1; i <= 8; i++)
		begin
			idx = 3'(last + i);
			if (open[idx] && mask[idx])
				return {2'b10, idx};
		end
		return {2'b00, last};
	endfunction

	task automatic compare_sel(sel_t got, sel_t exp, string name);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("Mismatch at %0t: %s got %0h expected %0h", $time, name, got, exp);
		end
	endtask

	task automatic compare_sample(sample_t got, sample_t exp, string name);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("Mismatch at %0t: %s got %0h expected %0h", $time, name, got, exp);
		end
	endtask

	task automatic compare_data(logic [31:0] got, logic [31:0] exp, string name);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("Mismatch at %0t: %s got %0h expected %0h", $time, name, got, exp);
		end
	endtask

	task automatic apb_write(logic [3:0] addr, logic [31:0] data, logic exp_err);
		@(posedge clock) #2;
		{psel, penable, pwrite, paddr, pwdata} = {3'b101, addr, data};
		@(posedge clock) #2;
		penable = 1'b1;
		#10 compare_data(32'(pslverr), 32'(exp_err), "pslverr");
		@(posedge clock) #2;
		{psel, penable} = 2'b00;
		if (!exp_err && addr == REG_CTRL) m_scan = data[0];
		if (!exp_err && addr == REG_DWELL) m_dwell = data[15:0];
		if (!exp_err && addr == REG_MASK) m_mask = data[7:0];
	endtask

	task automatic apb_read(logic [3:0] addr, output logic [31:0] data, input logic exp_err);
		@(posedge clock) #2;
		{psel, penable, pwrite, paddr} = {3'b100, addr};
		@(posedge clock) #2;
		penable = 1'b1;
		#10 compare_data(32'(pslverr), 32'(exp_err), "pslverr");
		data = prdata;
		@(posedge clock) #2;
		{psel, penable} = 2'b00;
	endtask

	task automatic wait_expiries(int n);
		int target;
		target = exp_count + n;
		while (exp_count < target)
			@(negedge clock);
	endtask

	// Sources change 2 ns after the edge and carry their index in the upper bits.
	always @(posedge clock)
	begin
		#2 tick <= tick + 12'd1;
		for (int i = 0; i < `NUM_STREAMS; i++)
			stream_samples[i] <= {4'(i), tick};
		bt_sample <= {4'hB, tick};
	end

	// ======================================================================
	// Reference model, stepped on each rising edge
	// ======================================================================
	always @(posedge clock)
	begin
		if (!rst_n)
		begin
			{cnt, m_sel, m_valid, m_last, m_hvalid, m_ovr, m_sample} = '0;
		end
		else
		begin
			if (!m_valid) m_sample = '0;
			else if (m_sel == 4'd8) m_sample = bt_sample;
			else m_sample = stream_samples[m_sel[2:0]];
			run = m_scan && bt_state;
			exp_now = run && (cnt == ((m_dwell < 2) ? dwell_t'(1) : m_dwell - 1));
			cnt = (!run || exp_now) ? '0 : cnt + 1;
			if (exp_now) exp_count++;
			if (!bt_state)
			begin
				{m_sel, m_valid, m_ovr} = {4'd8, 2'b11};
			end
			else if (m_ovr)
			begin
				{m_sel, m_valid, m_ovr} = {1'b0, m_last, m_hvalid, 1'b0};
			end
			else if (exp_now)
			begin
				nxt = next_stream(m_last, open_streams, m_mask);
				{m_hvalid, m_valid} = {2{nxt[4]}};
				if (nxt[4]) {m_sel, m_last} = {1'b0, nxt[2:0], nxt[2:0]};
			end
		end
	end

	always @(negedge clock)
	begin
		if (rst_n)
		begin
			compare_sel(sel, m_sel, "sel");
			compare_data(32'(sel_valid), 32'(m_valid), "sel_valid");
			compare_sample(sample_out, m_sample, "sample_out");
		end
	end

	always @(posedge clock)
	begin
		cycles++;
		if (cycles > MAX_CYCLES)
		begin
			$display("Timeout after %0d cycles, the run did not finish", cycles);
			$display("FAIL: see errors above");
			$finish;
		end
	end

	initial
	begin
		{rst_n, bt_state, psel, penable, pwrite, paddr, pwdata} = '0;
		open_streams = '0;
		{m_scan, m_dwell, m_mask} = {1'b1, dwell_t'(`DWELL_RESET), 8'hFF};
		repeat (4) @(posedge clock);
		#2 {rst_n, bt_state, open_streams} = {2'b11, 8'hFF};

		// Register access and error responses.
		apb_read(REG_DWELL, rdata, 1'b0);
		compare_data(rdata, 32'd385, "DWELL");
		apb_read(REG_MASK, rdata, 1'b0);
		compare_data(rdata, 32'hFF, "MASK");
		apb_read(REG_CTRL, rdata, 1'b0);
		compare_data(rdata, 32'h1, "CTRL");
		apb_write(REG_CTRL, 32'h0, 1'b0); // Clears the dwell count first.
		apb_write(REG_DWELL, 32'd5, 1'b0);
		apb_write(REG_MASK, 32'h5A, 1'b0);
		apb_write(4'h5, 32'hFFFF, 1'b1);
		apb_write(REG_STATUS, 32'h3F, 1'b1);
		apb_read(4'h5, rdata, 1'b1);
		apb_read(REG_CTRL, rdata, 1'b0);
		compare_data(rdata, 32'h0, "CTRL");
		apb_read(REG_DWELL, rdata, 1'b0);
		compare_data(rdata, 32'd5, "DWELL");
		apb_read(REG_MASK, rdata, 1'b0);
		compare_data(rdata, 32'h5A, "MASK");
		apb_write(REG_MASK, 32'hFF, 1'b0);
		apb_write(REG_CTRL, 32'h1, 1'b0);

		// Round-robin over all streams, starting from stream 0 after reset.
		for (int k = 1; k <= 9; k++)
		begin
			wait_expiries(1);
			compare_sel(sel, sel_t'(k % 8), "sel step");
			@(negedge clock);
			compare_sel(sel_t'(sample_out[15:12]), sel_t'(k % 8), "sample src");
		end

		// Random open patterns and masks.
		for (int k = 0; k < 12; k++)
		begin
			@(posedge clock) #2 open_streams = 8'($random(seed));
			apb_write(REG_MASK, 32'($random(seed)) & 32'hFF, 1'b0);
			wait_expiries(2);
		end
		@(posedge clock) #2 open_streams = '0;
		wait_expiries(1);
		repeat (2) @(negedge clock);
		compare_data(32'(sel_valid), 32'h0, "sel_valid idle");
		compare_sample(sample_out, '0, "sample_out idle");
		@(posedge clock) #2 open_streams = 8'hFF;
		apb_write(REG_MASK, 32'hFF, 1'b0);
		wait_expiries(2);

		// Bluetooth override, then resume.
		start_sel = m_sel;
		@(posedge clock) #2 bt_state = 1'b0;
		apb_read(REG_STATUS, rdata, 1'b0);
		compare_data(rdata, 32'h38, "STATUS override");
		repeat (17) @(posedge clock);
		#2 bt_state = 1'b1;
		repeat (2) @(negedge clock);
		compare_sel(sel, start_sel, "sel restored");
		wait_expiries(2);

		// Scan disable holds the selection.
		apb_write(REG_CTRL, 32'h0, 1'b0);
		start_sel = m_sel;
		apb_read(REG_STATUS, rdata, 1'b0);
		compare_data(rdata, 32'({2'b01, start_sel}), "STATUS");
		repeat (25) @(negedge clock);
		compare_sel(sel, start_sel, "sel held");
		apb_write(REG_CTRL, 32'h1, 1'b0);
		wait_expiries(2);
		repeat (3) @(negedge clock);

		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

endmodule

// ==== compile.f ====
+incdir+logic
logic/stream_switch_pkg.sv
logic/dwell_timer.sv
logic/stream_scan_arbiter.sv
logic/stream_mux.sv
logic/switch_apb_regs.sv
logic/stream_switch_top.sv
dv/stream_switch_checker.sv
dv/stream_switch_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= stream_switch_tb
BUILD     ?= obj_dir
LOG       ?= sim.log
FILELIST  ?= compile.f
VFLAGS    ?= --timing --assert

BIN := $(BUILD)/V$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

$(BIN): $(FILELIST) $(wildcard logic/*.sv logic/*.svh dv/*.sv)
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD)

sim: $(BIN)
	./$(BIN) | tee $(LOG)
	@grep -q "PASS: all tests" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD) $(LOG)
